// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing
TOP       := tb_packet_scanner
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dfa_hexrun.sv ====
`timescale 1ns/10ps
`default_nettype none

module dfa_hexrun (
  input  logic [scan_pkg::STATE_W-1:0] state_in,
  input  logic [scan_pkg::CHAR_W-1:0]  char_in,
  output logic [scan_pkg::STATE_W-1:0] state_out,
  output logic                         accept
);

  // Character classes
  logic is_digit;
  logic is_lower;
  logic is_upper;
  logic is_hex;

  assign is_digit = (char_in >= "0") && (char_in <= "9");
  assign is_lower = (char_in >= "a") && (char_in <= "f");
  assign is_upper = (char_in >= "A") && (char_in <= "F");
  assign is_hex = is_digit | is_lower | is_upper;

  always_comb
  begin
    if (!is_hex)
    begin
      // Run broken
      state_out = '0;
    end
    else if (state_in >= scan_pkg::HEX_RUN_LEN)
    begin
      // Saturate so a long run stays parked at the limit
      state_out = scan_pkg::HEX_RUN_LEN;
    end
    else
    begin
      state_out = state_in + 1'b1;
    end
  end

  // Fires once, on the digit that completes the run
  assign accept = is_hex && (state_in == scan_pkg::HEX_RUN_LEN - 1'b1);

endmodule

`default_nettype wire

// ==== dfa_literal.sv ====
`timescale 1ns/10ps
`default_nettype none

module dfa_literal (
  input  logic [scan_pkg::STATE_W-1:0] state_in,
  input  logic [scan_pkg::CHAR_W-1:0]  char_in,
  output logic [scan_pkg::STATE_W-1:0] state_out,
  output logic                         accept
);

  // Lower-case folded character
  logic [scan_pkg::CHAR_W-1:0] ch;
  // Prefix position 0..4 of the current state
  logic [2:0] pos;
  // Next prefix position
  logic [2:0] nxt;
  // Upper state bits must be zero for a legal state
  logic       legal;

  // Fold A..Z onto a..z by setting bit 5
  assign ch = ((char_in >= "A") && (char_in <= "Z")) ? (char_in | 8'h20) : char_in;

  assign pos = state_in[2:0];
  assign legal = (state_in[scan_pkg::STATE_W-1:3] == '0);

  always_comb
  begin
    // Mismatch fallback, an "e" always starts a new prefix
    nxt = (ch == "e") ? 3'd1 : 3'd0;
    if (legal)
    begin
      case (pos)
        3'd1: if (ch == "v") nxt = 3'd2;
        3'd2: if (ch == "i") nxt = 3'd3;
        3'd3: if (ch == "l") nxt = 3'd4;
        // States 0 and 4 only leave through the fallback
        default: ;
      endcase
    end
  end

  assign state_out = {{(scan_pkg::STATE_W-3){1'b0}}, nxt};

  // Only the step 3 -> 4 lands on the accept state
  assign accept = (state_out == scan_pkg::LIT_ACCEPT);

endmodule

`default_nettype wire

// ==== packet_scanner.sv ====
`timescale 1ns/10ps
`default_nettype none

module packet_scanner (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           load_state,
  input  logic                           new_stream,
  input  logic [scan_pkg::STREAM_W-1:0]  stream_id,
  input  logic                           char_vld,
  input  logic [scan_pkg::CHAR_W-1:0]    char_in,
  input  logic                           eop,
  input  logic [1:0]                     rule_enable,
  output logic                           verdict_vld,
  output logic [scan_pkg::VERDICT_W-1:0] verdict,
  output logic                           alert,
  output logic [scan_pkg::COUNT_W-1:0]   count_literal,
  output logic [scan_pkg::COUNT_W-1:0]   count_hexrun,
  output logic [scan_pkg::COUNT_W-1:0]   alert_count
);

  // Literal matcher end-of-packet strobe, also the combiner's packet marker
  logic done_literal;
  // Per-packet results of both rules
  logic fired_literal;
  logic fired_hexrun;

  // Literal "evil" rule
  stream_matcher #(
    .RULE (scan_pkg::RULE_LITERAL)
  ) match_lit0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_state (load_state),
    .new_stream (new_stream),
    .stream_id  (stream_id),
    .char_vld   (char_vld),
    .char_in    (char_in),
    .eop        (eop),
    .enable     (rule_enable[scan_pkg::RULE_LITERAL]),
    .done       (done_literal),
    .fired      (fired_literal),
    .count      (count_literal)
  );

  // Hex-run rule
  // Its done coincides with the literal one, so it is left open
  stream_matcher #(
    .RULE (scan_pkg::RULE_HEXRUN)
  ) match_hex0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_state (load_state),
    .new_stream (new_stream),
    .stream_id  (stream_id),
    .char_vld   (char_vld),
    .char_in    (char_in),
    .eop        (eop),
    .enable     (rule_enable[scan_pkg::RULE_HEXRUN]),
    .done       (),
    .fired      (fired_hexrun),
    .count      (count_hexrun)
  );

  // Per-packet verdict and alert
  verdict_combiner comb0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .done          (done_literal),
    .fired_literal (fired_literal),
    .fired_hexrun  (fired_hexrun),
    .verdict_vld   (verdict_vld),
    .alert         (alert),
    .verdict       (verdict),
    .alert_count   (alert_count)
  );

endmodule

`default_nettype wire

// ==== scan_pkg.sv ====
`default_nettype none

package scan_pkg;

  // Width of one DFA state word
  localparam int STATE_W = 11;

  // Stream id width and number of context entries
  localparam int STREAM_W = 6;
  localparam int NUM_STREAMS = 64;

  // Payload character width
  localparam int CHAR_W = 8;

  // All event counters share this width
  localparam int COUNT_W = 16;

  // Rule selectors, also the bit index in rule_enable and verdict
  localparam int RULE_LITERAL = 0;
  localparam int RULE_HEXRUN = 1;

  // Number of consecutive hex digits that fires the hex-run rule
  localparam logic [STATE_W-1:0] HEX_RUN_LEN = STATE_W'(16);

  // Literal DFA state after the final "l" of "evil"
  localparam logic [STATE_W-1:0] LIT_ACCEPT = STATE_W'(4);

  // Verdict word, one bit per rule
  localparam int VERDICT_W = 2;

endpackage

`default_nettype wire

// ==== sim.f ====
scan_pkg.sv
dfa_literal.sv
dfa_hexrun.sv
stream_matcher.sv
verdict_combiner.sv
packet_scanner.sv
tb_packet_scanner.sv

// ==== stream_matcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_matcher #(
  parameter int RULE = scan_pkg::RULE_LITERAL
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load_state,
  input  logic                          new_stream,
  input  logic [scan_pkg::STREAM_W-1:0] stream_id,
  input  logic                          char_vld,
  input  logic [scan_pkg::CHAR_W-1:0]   char_in,
  input  logic                          eop,
  input  logic                          enable,
  output logic                          done,
  output logic                          fired,
  output logic [scan_pkg::COUNT_W-1:0]  count
);

  // Saved DFA state per stream
  logic [scan_pkg::STATE_W-1:0] ctx_mem [scan_pkg::NUM_STREAMS];

  // Registered input stage
  logic                          load_r;
  logic                          new_r;
  logic [scan_pkg::STREAM_W-1:0] id_r;
  logic                          vld_r;
  logic [scan_pkg::CHAR_W-1:0]   char_r;
  logic                          eop_r;
  logic                          en_r;

  // Stream of the packet in flight
  logic [scan_pkg::STREAM_W-1:0] cur_sid;
  // Live DFA state
  logic [scan_pkg::STATE_W-1:0]  cur_state;
  // Sticky per-packet match flag
  logic                          hit;

  // DFA outputs
  logic [scan_pkg::STATE_W-1:0]  dfa_state;
  logic                          dfa_accept;

  // Control strobes of the input stage
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      load_r <= 1'b0;
      vld_r <= 1'b0;
      eop_r <= 1'b0;
    end
    else
    begin
      load_r <= load_state;
      vld_r <= char_vld;
      eop_r <= eop;
    end
  end

  // Payload side of the input stage
  always_ff @(posedge clk)
  begin
    new_r <= new_stream;
    id_r <= stream_id;
    char_r <= char_in;
    en_r <= enable;
  end

  // Remember which stream this packet belongs to for the save at eop
  always_ff @(posedge clk)
  begin
    if (load_r)
      cur_sid <= id_r;
  end

  // Rule selection
  generate
    if (RULE == scan_pkg::RULE_HEXRUN)
    begin : g_hexrun
      dfa_hexrun dfa0 (
        .state_in  (cur_state),
        .char_in   (char_r),
        .state_out (dfa_state),
        .accept    (dfa_accept)
      );
    end
    else
    begin : g_literal
      dfa_literal dfa0 (
        .state_in  (cur_state),
        .char_in   (char_r),
        .state_out (dfa_state),
        .accept    (dfa_accept)
      );
    end
  endgenerate

  // Packet state, result flags and counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cur_state <= '0;
      hit <= 1'b0;
      done <= 1'b0;
      fired <= 1'b0;
      count <= '0;
    end
    else
    begin
      done <= eop_r;
      if (load_r)
      begin
        // Resume the stream or start it clean
        cur_state <= new_r ? '0 : ctx_mem[id_r];
        hit <= 1'b0;
      end
      else if (vld_r)
      begin
        cur_state <= dfa_state;
        if (dfa_accept)
          hit <= 1'b1;
      end
      if (eop_r)
      begin
        // A disabled rule reports nothing for this packet
        fired <= en_r & hit;
        if (en_r && hit)
          count <= count + 1'b1;
      end
    end
  end

  // Context save, skipped when the rule is off so the old state survives
  always_ff @(posedge clk)
  begin
    if (eop_r && en_r)
      ctx_mem[cur_sid] <= cur_state;
  end

endmodule

`default_nettype wire

// ==== tb_packet_scanner.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_packet_scanner;

  // Run length limits
  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_ENTRY = 40;

  logic                           clk;
  logic                           rst_n;
  logic                           load_state;
  logic                           new_stream;
  logic [scan_pkg::STREAM_W-1:0]  stream_id;
  logic                           char_vld;
  logic [scan_pkg::CHAR_W-1:0]    char_in;
  logic                           eop;
  logic [1:0]                     rule_enable;
  logic                           verdict_vld;
  logic [scan_pkg::VERDICT_W-1:0] verdict;
  logic                           alert;
  logic [scan_pkg::COUNT_W-1:0]   count_literal;
  logic [scan_pkg::COUNT_W-1:0]   count_hexrun;
  logic [scan_pkg::COUNT_W-1:0]   alert_count;

  // Packet table, one slot per entry in every queue
  string                          name_q[$];
  logic [scan_pkg::STREAM_W-1:0]  sid_q[$];
  logic                           new_q[$];
  logic [1:0]                     en_q[$];
  string                          payload_q[$];
  logic [scan_pkg::VERDICT_W-1:0] verdict_q[$];
  logic                           table_built;

  // Running totals derived from the expected verdicts
  int exp_lit;
  int exp_hex;
  int exp_alert;

  packet_scanner dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_state    (load_state),
    .new_stream    (new_stream),
    .stream_id     (stream_id),
    .char_vld      (char_vld),
    .char_in       (char_in),
    .eop           (eop),
    .rule_enable   (rule_enable),
    .verdict_vld   (verdict_vld),
    .verdict       (verdict),
    .alert         (alert),
    .count_literal (count_literal),
    .count_hexrun  (count_hexrun),
    .alert_count   (alert_count)
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task add_entry(input string name, input logic [scan_pkg::STREAM_W-1:0] sid,
                 input logic new_s, input logic [1:0] en, input string payload,
                 input logic [scan_pkg::VERDICT_W-1:0] exp_verdict);
    name_q.push_back(name);
    sid_q.push_back(sid);
    new_q.push_back(new_s);
    en_q.push_back(en);
    payload_q.push_back(payload);
    verdict_q.push_back(exp_verdict);
  endtask

  // Verdict bit 0 is the literal rule, bit 1 the hex run
  task build_table;
    add_entry("lit_single", 6'd1, 1'b1, 2'b11, "xxEvIlxx", 2'b01);
    add_entry("hex_single", 6'd2, 1'b1, 2'b11, "zz0123456789abcdefzz", 2'b10);
    add_entry("both_rules", 6'd3, 1'b1, 2'b11, "EVIL-0123456789ABCDEF-", 2'b11);
    // Literal split over two packets of stream 5, stream 9 in between
    add_entry("lit_split_a", 6'd5, 1'b1, 2'b11, "..ev", 2'b00);
    add_entry("other_stream", 6'd9, 1'b1, 2'b11, "nothing", 2'b00);
    add_entry("lit_split_b", 6'd5, 1'b0, 2'b11, "il..", 2'b01);
    // Hex run of 10 then 6
    add_entry("hex_split_a", 6'd7, 1'b1, 2'b11, "..0123456789", 2'b00);
    add_entry("hex_split_b", 6'd7, 1'b0, 2'b11, "abcdef..", 2'b10);
    // Same splits, second half marked as a new stream
    add_entry("hex_new_a", 6'd11, 1'b1, 2'b11, "--0123456789", 2'b00);
    add_entry("hex_new_b", 6'd11, 1'b1, 2'b11, "abcdef--", 2'b00);
    add_entry("lit_new_a", 6'd12, 1'b1, 2'b11, "..ev", 2'b00);
    add_entry("lit_new_b", 6'd12, 1'b1, 2'b11, "il..", 2'b00);
    // Literal off on the closing packet, then resumed with it on
    add_entry("dis_lit_a", 6'd20, 1'b1, 2'b11, "xev", 2'b00);
    add_entry("dis_lit_b", 6'd20, 1'b0, 2'b10, "il", 2'b00);
    add_entry("dis_lit_c", 6'd20, 1'b0, 2'b11, "il", 2'b01);
    // Hex run off on the closing packet
    add_entry("dis_hex_a", 6'd21, 1'b1, 2'b11, "0123456789", 2'b00);
    add_entry("dis_hex_b", 6'd21, 1'b0, 2'b01, "abcdef", 2'b00);
    add_entry("dis_hex_c", 6'd21, 1'b0, 2'b11, "ABCDEF", 2'b10);
    // 40 digit run over two packets fires once
    add_entry("hex_long_a", 6'd30, 1'b1, 2'b11, "0123456789abcdef01234567", 2'b10);
    add_entry("hex_long_b", 6'd30, 1'b0, 2'b11, "89abcdef01234567", 2'b00);
    add_entry("empty", 6'd40, 1'b1, 2'b11, "", 2'b00);
    // Two hits in one packet count once
    add_entry("evil_twice", 6'd1, 1'b0, 2'b11, "EVILevil", 2'b01);
    add_entry("alert_again", 6'd2, 1'b0, 2'b11, "evil0123456789ABCDEF", 2'b11);
  endtask

  task check_field(input string test_name, input string field,
                   input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("mismatch %s %s expected %0h actual %0h", test_name, field, expected, actual);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Step to just after the next rising edge
  task next_cycle;
    @(posedge clk);
    #1;
  endtask

  task drive_idle;
    load_state = 1'b0;
    new_stream = 1'b0;
    char_vld = 1'b0;
    char_in = '0;
    eop = 1'b0;
  endtask

  // Load cycle, one cycle per character, then eop
  task send_packet(input int idx);
    string payload;
    int i;
    payload = payload_q[idx];
    next_cycle();
    drive_idle();
    load_state = 1'b1;
    new_stream = new_q[idx];
    stream_id = sid_q[idx];
    for (i = 0; i < payload.len(); i++)
    begin
      next_cycle();
      drive_idle();
      char_vld = 1'b1;
      char_in = payload[i];
    end
    next_cycle();
    drive_idle();
    eop = 1'b1;
    // Enables only matter in the eop cycle
    rule_enable = en_q[idx];
    next_cycle();
    drive_idle();
  endtask

  // Sample on the falling edge, away from the DUT's updates
  task wait_verdict;
    while (verdict_vld !== 1'b1)
      @(negedge clk);
  endtask

  task check_entry(input int idx);
    logic [scan_pkg::VERDICT_W-1:0] exp_v;
    logic                           exp_alert_bit;
    exp_v = verdict_q[idx];
    exp_alert_bit = exp_v[scan_pkg::RULE_LITERAL] & exp_v[scan_pkg::RULE_HEXRUN];
    if (exp_v[scan_pkg::RULE_LITERAL])
      exp_lit++;
    if (exp_v[scan_pkg::RULE_HEXRUN])
      exp_hex++;
    if (exp_alert_bit)
      exp_alert++;
    check_field(name_q[idx], "verdict", 32'(exp_v), 32'(verdict));
    check_field(name_q[idx], "alert", 32'(exp_alert_bit), 32'(alert));
    check_field(name_q[idx], "count_literal", 32'(exp_lit), 32'(count_literal));
    check_field(name_q[idx], "count_hexrun", 32'(exp_hex), 32'(count_hexrun));
    check_field(name_q[idx], "alert_count", 32'(exp_alert), 32'(alert_count));
  endtask

  initial
  begin
    int idx;
    int gap;
    void'($urandom(32'he84));
    table_built = 1'b0;
    rst_n = 1'b0;
    stream_id = '0;
    rule_enable = 2'b11;
    drive_idle();
    exp_lit = 0;
    exp_hex = 0;
    exp_alert = 0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    // Outputs quiet and counters cleared out of reset
    @(negedge clk);
    check_field("reset", "verdict_vld", 32'd0, 32'(verdict_vld));
    check_field("reset", "alert", 32'd0, 32'(alert));
    check_field("reset", "count_literal", 32'd0, 32'(count_literal));
    check_field("reset", "count_hexrun", 32'd0, 32'(count_hexrun));
    check_field("reset", "alert_count", 32'd0, 32'(alert_count));
    for (idx = 0; idx < name_q.size(); idx++)
    begin
      send_packet(idx);
      wait_verdict();
      check_entry(idx);
      // Idle gap of 0 to 3 cycles
      gap = $urandom % 4;
      repeat (gap) next_cycle();
    end
    $display("All tests passed");
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    wait (table_built === 1'b1);
    repeat (RESET_CYCLES + CYCLES_PER_ENTRY * name_q.size()) @(posedge clk);
    $display("timeout: verdict_vld never arrived");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== verdict_combiner.sv ====
`timescale 1ns/10ps
`default_nettype none

module verdict_combiner (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           done,
  input  logic                           fired_literal,
  input  logic                           fired_hexrun,
  output logic                           verdict_vld,
  output logic                           alert,
  output logic [scan_pkg::VERDICT_W-1:0] verdict,
  output logic [scan_pkg::COUNT_W-1:0]   alert_count
);

  // Both rules hit the same packet
  logic both;

  assign both = fired_literal & fired_hexrun;

  // Strobe, alert and alert counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      verdict_vld <= 1'b0;
      alert <= 1'b0;
      alert_count <= '0;
    end
    else
    begin
      verdict_vld <= done;
      // Alert pulses together with verdict_vld
      alert <= done & both;
      if (done && both)
        alert_count <= alert_count + 1'b1;
    end
  end

  // Verdict word, one bit per rule
  always_ff @(posedge clk)
  begin
    if (done)
    begin
      verdict[scan_pkg::RULE_LITERAL] <= fired_literal;
      verdict[scan_pkg::RULE_HEXRUN] <= fired_hexrun;
    end
  end

endmodule

`default_nettype wire
